// ==== hdl/rf_consts.svh ====
// Width constants shared by the register-file subsystem
// RF_ADDR_W sets the register count, 4 gives the 16-register variant
// The command word layout assumes RF_ADDR_W of at most 5
// RF_IMM_W must fit above bit 17 of a RF_DATA_W command word

`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Register and bus data width
`define RF_DATA_W 32

// Register index width
`define RF_ADDR_W 5

// Number of architectural registers, register 0 included
`define RF_NUM_REGS (1 << `RF_ADDR_W)

// Immediate field of a load-immediate command
`define RF_IMM_W 14

////////////////////////////////////////////////////////////////////////////
// Bus
////////////////////////////////////////////////////////////////////////////

// Wishbone byte address width, top bit selects register reads
`define RF_BUS_ADR_W 8

`endif

// ==== hdl/rf_pkg.sv ====
// Types for the register-file subsystem
// Widths come from the macros in the constants header
//
// Command word, written over Wishbone with address bit 7 clear
//   bits  2..0   operation
//   bits  7..3   rd
//   bits 12..8   rs1
//   bits 17..13  rs2
//   bits 31..18  immediate, zero-extended, used by OP_LI only

`include "rf_consts.svh"

package rf_pkg;

  // One data word
  typedef logic [`RF_DATA_W-1:0] rf_word_t;

  // Register index
  typedef logic [`RF_ADDR_W-1:0] rf_idx_t;

  // Load-immediate field, zero-extended on use
  typedef logic [`RF_IMM_W-1:0] rf_imm_t;

  // ALU operations
  // Shifts take the low 5 bits of the second operand
  // OP_LI writes the zero-extended immediate to rd
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    OP_LI  = 3'd7
  } rf_op_e;

endpackage

// ==== hdl/rf_if.sv ====
// Internal links between the command slave, register file and execute stage
// Register reads are combinational, data follows the address in the same cycle
// The issue path has no ready, the execute stage accepts every pulse

`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// Operand read ports
////////////////////////////////////////////////////////////////////////////

interface rf_read_if
  import rf_pkg::*;
();

  // Port A, first source operand
  rf_idx_t  raddr_a;
  rf_word_t rdata_a;

  // Port B, second source operand or bus register read
  rf_idx_t  raddr_b;
  rf_word_t rdata_b;

  // Command slave side
  modport requester (output raddr_a, output raddr_b, input rdata_a, input rdata_b);

  // Register file side
  modport provider (input raddr_a, input raddr_b, output rdata_a, output rdata_b);

endinterface

////////////////////////////////////////////////////////////////////////////
// Operation issue
////////////////////////////////////////////////////////////////////////////

interface exec_if
  import rf_pkg::*;
();

  // Single-cycle pulse per issued command
  logic     valid;
  rf_op_e   op;
  rf_idx_t  rd;
  // Operand values, opb holds the immediate for OP_LI
  rf_word_t opa;
  rf_word_t opb;

  modport issue (output valid, output op, output rd, output opa, output opb);

  modport exec (input valid, input op, input rd, input opa, input opb);

endinterface

// ==== hdl/wb_cmd_slave.sv ====
// Wishbone classic slave, no errors, retry or bursts
// Master must hold cyc, stb and data until ack and drop stb after it
// Address bit 7 clear with we: command, bit 7 set without we: register read
// Ack is registered, one cycle after strobe, never stalls

`timescale 1ns/10ps

`include "rf_consts.svh"

module wb_cmd_slave
  import rf_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Wishbone slave port
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`RF_BUS_ADR_W-1:0] wb_adr_i,
  input  rf_word_t                 wb_dat_i,
  output rf_word_t                 wb_dat_o,
  output logic                     wb_ack_o,

  // Operand reads
  rf_read_if.requester             rd_o,

  // Operation issue
  exec_if.issue                    iss_o
);

  // Bus address decode
  localparam int unsigned adr_sel_bit = `RF_BUS_ADR_W - 1;
  localparam int unsigned adr_idx_lsb = 2;

  // Command word field positions
  localparam int unsigned op_lsb  = 0;
  localparam int unsigned rd_lsb  = 3;
  localparam int unsigned rs1_lsb = 8;
  localparam int unsigned rs2_lsb = 13;
  localparam int unsigned imm_lsb = 18;

  logic     ack_q;
  logic     valid_q;
  rf_word_t dat_q;
  rf_op_e   op_q;
  rf_idx_t  rd_q;
  rf_word_t opa_q;
  rf_word_t opb_q;

  logic     req;
  logic     reg_sel;
  logic     cmd_wr;
  logic     reg_rd;
  rf_idx_t  bus_idx;

  rf_op_e   cmd_op;
  rf_idx_t  cmd_rd;
  rf_idx_t  cmd_rs1;
  rf_idx_t  cmd_rs2;
  rf_imm_t  cmd_imm;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  // New strobe only, the ack cycle itself is masked
  assign req     = wb_cyc_i & wb_stb_i & ~ack_q;
  assign reg_sel = wb_adr_i[adr_sel_bit];
  assign cmd_wr  = req & wb_we_i & ~reg_sel;
  assign reg_rd  = req & ~wb_we_i & reg_sel;
  assign bus_idx = wb_adr_i[adr_idx_lsb +: `RF_ADDR_W];

  // Command fields, taken straight from the write data
  assign cmd_op  = rf_op_e'(wb_dat_i[op_lsb +: 3]);
  assign cmd_rd  = wb_dat_i[rd_lsb +: `RF_ADDR_W];
  assign cmd_rs1 = wb_dat_i[rs1_lsb +: `RF_ADDR_W];
  assign cmd_rs2 = wb_dat_i[rs2_lsb +: `RF_ADDR_W];
  assign cmd_imm = wb_dat_i[imm_lsb +: `RF_IMM_W];

  // Port B doubles as the bus read port
  assign rd_o.raddr_a = cmd_rs1;
  assign rd_o.raddr_b = wb_we_i ? cmd_rs2 : bus_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Acknowledge, issue and read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      ack_q   <= req;
      // Issue lands on the same edge as ack
      valid_q <= cmd_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr) begin
      op_q  <= cmd_op;
      rd_q  <= cmd_rd;
      opa_q <= rd_o.rdata_a;
      // Load-immediate carries its value on operand B
      opb_q <= (cmd_op == OP_LI) ? {{(`RF_DATA_W - `RF_IMM_W){1'b0}}, cmd_imm}
                                 : rd_o.rdata_b;
    end
    // Zero for command writes and low-half reads
    if (req) begin
      dat_q <= reg_rd ? rd_o.rdata_b : '0;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

  assign iss_o.valid = valid_q;
  assign iss_o.op    = op_q;
  assign iss_o.rd    = rd_q;
  assign iss_o.opa   = opa_q;
  assign iss_o.opb   = opb_q;

endmodule

// ==== hdl/reg_file.sv ====
// Flip-flop register file, two combinational reads and one write
// Register 0 is hard-wired to zero, writes to it are dropped
// Register count follows RF_ADDR_W

`timescale 1ns/10ps

`include "rf_consts.svh"

module reg_file
  import rf_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Read ports A and B
  rf_read_if.provider  rd_i,

  // Write-back port
  input  logic         we_i,
  input  rf_idx_t      waddr_i,
  input  rf_word_t     wdata_i
);

  localparam int unsigned num_regs = `RF_NUM_REGS;

  // Full view with register 0 as constant
  rf_word_t [num_regs-1:0] regs;
  // Storage, register 0 has none
  rf_word_t [num_regs-1:1] regs_q;
  logic     [num_regs-1:1] we_dec;

  // One-hot write enable per register
  always_comb begin
    for (int unsigned i = 1; i < num_regs; i++) begin
      we_dec[i] = we_i && (waddr_i == rf_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else begin
      for (int unsigned r = 1; r < num_regs; r++) begin
        if (we_dec[r]) begin
          regs_q[r] <= wdata_i;
        end
      end
    end
  end

  assign regs[0]            = '0;
  assign regs[num_regs-1:1] = regs_q;

  // Combinational reads, no bypass of a same-cycle write
  assign rd_i.rdata_a = regs[rd_i.raddr_a];
  assign rd_i.rdata_b = regs[rd_i.raddr_b];

endmodule

// ==== hdl/exec_stage.sv ====
// Single-cycle ALU with a registered write-back
// Accepts one operation per valid pulse, no stall
// Shifts use the low bits of operand B, register 0 writes pass through

`timescale 1ns/10ps

`include "rf_consts.svh"

module exec_stage
  import rf_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // Issued operation
  exec_if.exec     iss_i,

  // Write-back to the register file
  output logic     we_o,
  output rf_idx_t  waddr_o,
  output rf_word_t wdata_o
);

  // Shift amount width, 5 for 32-bit data
  localparam int unsigned shamt_w = $clog2(`RF_DATA_W);

  logic [shamt_w-1:0] shamt;
  rf_word_t           alu_res;

  logic               we_q;
  rf_idx_t            waddr_q;
  rf_word_t           wdata_q;

  assign shamt = iss_i.opb[shamt_w-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (iss_i.op)
      OP_ADD:  alu_res = iss_i.opa + iss_i.opb;
      OP_SUB:  alu_res = iss_i.opa - iss_i.opb;
      OP_AND:  alu_res = iss_i.opa & iss_i.opb;
      OP_OR:   alu_res = iss_i.opa | iss_i.opb;
      OP_XOR:  alu_res = iss_i.opa ^ iss_i.opb;
      // Logical shifts only
      OP_SLL:  alu_res = iss_i.opa << shamt;
      OP_SRL:  alu_res = iss_i.opa >> shamt;
      // Immediate already zero-extended by the slave
      OP_LI:   alu_res = iss_i.opb;
      default: alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else begin
      we_q <= iss_i.valid;
    end
  end

  // Result and target, held until the next issue
  always_ff @(posedge clk_i) begin
    if (iss_i.valid) begin
      waddr_q <= iss_i.rd;
      wdata_q <= alu_res;
    end
  end

  assign we_o    = we_q;
  assign waddr_o = waddr_q;
  assign wdata_o = wdata_q;

endmodule

// ==== hdl/rv_alu_core.sv ====
// Register-file execution subsystem behind a Wishbone classic slave
// Strobe to ack is one cycle, strobe to register update three edges
// Dependent commands need no forwarding, the bus spacing covers it

`timescale 1ns/10ps

`include "rf_consts.svh"

module rv_alu_core
  import rf_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Wishbone slave port
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`RF_BUS_ADR_W-1:0] wb_adr_i,
  input  rf_word_t                 wb_dat_i,
  output rf_word_t                 wb_dat_o,
  output logic                     wb_ack_o
);

  // Write-back from execute to register file
  logic     rf_we;
  rf_idx_t  rf_waddr;
  rf_word_t rf_wdata;

  // Operand reads and issue path
  rf_read_if u_rd_if ();
  exec_if    u_iss_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Command slave, register file, execute stage
  ////////////////////////////////////////////////////////////////////////////

  wb_cmd_slave u_wb_cmd_slave (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .rd_o     (u_rd_if.requester),
    .iss_o    (u_iss_if.issue)
  );

  reg_file u_reg_file (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rd_i    (u_rd_if.provider),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  // One cycle after issue the result is written
  exec_stage u_exec_stage (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .iss_i   (u_iss_if.exec),
    .we_o    (rf_we),
    .waddr_o (rf_waddr),
    .wdata_o (rf_wdata)
  );

endmodule

// ==== bench/rv_alu_core_checker.sv ====
// Wishbone handshake and register 0 assertions for rv_alu_core
// Sampled on the rising clock, idle during reset
// Assumes a classic master that drops stb in the cycle after ack

`timescale 1ns/10ps

`include "rf_consts.svh"

module rv_alu_core_checker
  import rf_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     wb_cyc_i,
  input logic                     wb_stb_i,
  input logic                     wb_we_i,
  input logic [`RF_BUS_ADR_W-1:0] wb_adr_i,
  input rf_word_t                 wb_dat_o,
  input logic                     wb_ack_o
);

  localparam int unsigned adr_sel_bit = `RF_BUS_ADR_W - 1;

  // Failed assertions so far
  int unsigned assert_fails = 0;

  // Register read of x0 being acknowledged
  logic reg0_rd;
  assign reg0_rd = wb_ack_o && !wb_we_i && wb_adr_i[adr_sel_bit]
                   && (wb_adr_i[2 +: `RF_ADDR_W] == '0);

  a_ack_with_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else begin
      $error("ack high without cyc and stb");
      assert_fails++;
    end

  // One ack per strobe
  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o)
    else begin
      $error("ack held for more than one cycle");
      assert_fails++;
    end

  a_ack_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
    else begin
      $error("ack missing one cycle after strobe");
      assert_fails++;
    end

  a_reg0_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg0_rd |-> (wb_dat_o == '0))
    else begin
      $error("register 0 read returned nonzero data");
      assert_fails++;
    end

endmodule

bind rv_alu_core rv_alu_core_checker u_checker (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_we_i  (wb_we_i),
  .wb_adr_i (wb_adr_i),
  .wb_dat_o (wb_dat_o),
  .wb_ack_o (wb_ack_o)
);

// ==== bench/rv_alu_core_tb.sv ====
// Directed and random test of the Wishbone register-file core
// Inputs change and outputs are sampled 10 ns after each rising edge
// Every access ends with at least one idle cycle before the next strobe
// Expected register contents come from a model updated by ref_exec

`timescale 1ns/10ps

`include "rf_consts.svh"

module rv_alu_core_tb
  import rf_pkg::*;
();

  localparam int unsigned clk_period = 100;
  localparam int unsigned drive_dly  = 10;
  localparam int unsigned num_regs   = `RF_NUM_REGS;
  localparam int unsigned n_ops      = 120;
  localparam int unsigned n_zero     = 8;
  localparam int unsigned n_misc     = 8;
  // Upper bound of bus accesses over all phases
  localparam int unsigned max_trans  = 6 * num_regs + 2 * n_ops + n_zero + 2 * n_misc;
  // Allows 10 cycles per access where 7 is the most any access takes
  localparam int unsigned timeout_ns = (max_trans * 10 + 50) * clk_period;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`RF_BUS_ADR_W-1:0] wb_adr_i;
  rf_word_t                 wb_dat_i;
  rf_word_t                 wb_dat_o;
  logic                     wb_ack_o;

  // Register model and pending read results
  rf_word_t    model [num_regs];
  rf_word_t    got_q [$];
  rf_word_t    exp_q [$];
  string       name_q [$];
  int unsigned errors;
  int unsigned checks;
  logic [31:0] rng;

  rv_alu_core u_rv_alu_core (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin : clock
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout after %0d ns, the bus stopped acknowledging", timeout_ns);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers, command encoding, reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Fields sit at fixed bit positions whatever the register index width
  function automatic rf_word_t enc_cmd(input rf_op_e op, input rf_idx_t rd,
                                       input rf_idx_t rs1, input rf_idx_t rs2,
                                       input rf_imm_t imm);
    rf_word_t w;
    w                   = '0;
    w[2:0]              = op;
    w[3 +: `RF_ADDR_W]  = rd;
    w[8 +: `RF_ADDR_W]  = rs1;
    w[13 +: `RF_ADDR_W] = rs2;
    w[18 +: `RF_IMM_W]  = imm;
    return w;
  endfunction

  function automatic rf_word_t ref_exec(input rf_op_e op, input rf_word_t a,
                                        input rf_word_t b, input rf_imm_t imm);
    rf_word_t r;
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      // Shift amount from the low 5 bits
      OP_SLL:  r = a << b[4:0];
      OP_SRL:  r = a >> b[4:0];
      // Immediate in the low bits and zeros above
      OP_LI: begin
        r                = '0;
        r[`RF_IMM_W-1:0] = imm;
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic check_val(input string name, input rf_word_t got, input rf_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////////////////////////////

  // Sometimes cyc leads stb by one cycle
  task automatic start_cycle(input logic we, input logic [`RF_BUS_ADR_W-1:0] adr,
                             input rf_word_t dat);
    logic [31:0] r;
    r = rand_word();
    wb_cyc_i = 1'b1;
    if (r[2:0] == 3'd0) begin
      @(posedge clk_i);
      #(drive_dly);
    end
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
  endtask

  task automatic wait_ack();
    do begin
      @(posedge clk_i);
      #(drive_dly);
    end while (!wb_ack_o);
  endtask

  // One idle cycle covers the write-back two edges after ack
  task automatic end_cycle();
    int unsigned gap;
    gap = rand_word() % 4;
    @(posedge clk_i);
    #(drive_dly);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    repeat (gap + 1) @(posedge clk_i);
    #(drive_dly);
  endtask

  task automatic wb_write(input logic [`RF_BUS_ADR_W-1:0] adr, input rf_word_t dat);
    start_cycle(1'b1, adr, dat);
    wait_ack();
    end_cycle();
  endtask

  task automatic wb_read(input logic [`RF_BUS_ADR_W-1:0] adr, output rf_word_t dat);
    start_cycle(1'b0, adr, '0);
    wait_ack();
    dat = wb_dat_o;
    end_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Command and register access
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_cmd(input rf_op_e op, input rf_idx_t rd, input rf_idx_t rs1,
                           input rf_idx_t rs2, input rf_imm_t imm);
    logic [31:0] r;
    r = rand_word();
    // Low address bits do not matter for a command
    wb_write({1'b0, r[`RF_BUS_ADR_W-2:0]}, enc_cmd(op, rd, rs1, rs2, imm));
    if (rd != '0) begin
      model[rd] = ref_exec(op, model[rs1], model[rs2], imm);
    end
  endtask

  task automatic read_reg(input rf_idx_t idx);
    logic [`RF_BUS_ADR_W-1:0] adr;
    rf_word_t                 got;
    adr = '0;
    adr[`RF_BUS_ADR_W-1] = 1'b1;
    adr[2 +: `RF_ADDR_W] = idx;
    wb_read(adr, got);
    got_q.push_back(got);
    exp_q.push_back(model[idx]);
    name_q.push_back($sformatf("x%0d", idx));
  endtask

  task automatic dump_regs();
    for (int unsigned i = 0; i < num_regs; i++) begin
      read_reg(rf_idx_t'(i));
    end
  endtask

  // Compares read results as they arrive
  initial begin : compare
    forever begin
      @(posedge clk_i);
      while (got_q.size() > 0) begin
        check_val(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] r;
    logic [31:0] op_sel;
    rf_op_e      op;
    rf_idx_t     rd;
    rf_idx_t     rs1;
    rf_idx_t     prev_rd;
    rf_word_t    got;
    int unsigned afails;
    rng      = 32'ha67e_0e09;
    errors   = 0;
    checks   = 0;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    for (int unsigned i = 0; i < num_regs; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #(drive_dly);
    rst_ni = 1'b1;

    // All registers clear after reset
    dump_regs();

    // Load every register with a random immediate
    for (int unsigned i = 1; i < num_regs; i++) begin
      r = rand_word();
      issue_cmd(OP_LI, rf_idx_t'(i), r[8 +: `RF_ADDR_W], r[13 +: `RF_ADDR_W],
                r[18 +: `RF_IMM_W]);
      read_reg(rf_idx_t'(i));
    end

    // Random ALU ops with rs1 often the previous rd
    prev_rd = rf_idx_t'(1);
    for (int unsigned n = 0; n < n_ops; n++) begin
      r      = rand_word();
      op_sel = r % 7;
      op     = rf_op_e'(op_sel[2:0]);
      rd     = r[8 +: `RF_ADDR_W];
      rs1    = r[16] ? prev_rd : r[13 +: `RF_ADDR_W];
      issue_cmd(op, rd, rs1, r[20 +: `RF_ADDR_W], r[18 +: `RF_IMM_W]);
      if (r[31]) begin
        read_reg(rd);
      end
      prev_rd = rd;
    end
    dump_regs();

    // Commands aimed at x0
    for (int unsigned n = 0; n < n_zero; n++) begin
      r      = rand_word();
      op_sel = r % 8;
      issue_cmd(rf_op_e'(op_sel[2:0]), '0, r[8 +: `RF_ADDR_W], r[13 +: `RF_ADDR_W],
                r[18 +: `RF_IMM_W]);
    end
    dump_regs();

    // Low-half reads give zero and high-half writes do nothing
    for (int unsigned n = 0; n < n_misc; n++) begin
      r = rand_word();
      wb_read({1'b0, r[`RF_BUS_ADR_W-2:0]}, got);
      got_q.push_back(got);
      exp_q.push_back('0);
      name_q.push_back("wb_dat_o low read");
      wb_write({1'b1, r[`RF_BUS_ADR_W-2:0]}, rand_word());
    end
    dump_regs();

    repeat (2) @(posedge clk_i);
    afails = u_rv_alu_core.u_checker.assert_fails;
    $display("Checks %0d, mismatches %0d, assertion failures %0d", checks, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== rv_alu_core.f ====
+incdir+hdl
hdl/rf_pkg.sv
hdl/rf_if.sv
hdl/wb_cmd_slave.sv
hdl/reg_file.sv
hdl/exec_stage.sv
hdl/rv_alu_core.sv
bench/rv_alu_core_checker.sv
bench/rv_alu_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the rv_alu_core testbench

VERILATOR ?= verilator
TOP       ?= rv_alu_core_tb
FILELIST  ?= rv_alu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# Passes only if the pass message shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
